// ==== all.f ====
hookPkg.sv
angleSequencer.sv
quadrantLookup.sv
pixelEmitter.sv
hookPlotter.sv
tbClock.sv
hookPlotter_assert.sv
hookPlotter_tb.sv

// ==== angleSequencer.sv ====
`timescale 1ns/1ps

module angleSequencer (
    input  logic       clock,
    input  logic       resetn,
    input  logic       enable,
    input  logic [8:0] degree,
    input  logic       stall,
    input  logic       drained,
    output logic [8:0] angle,
    output logic       issueValid,
    output logic       busy,
    output logic       done
);

    hookPkg::seqState state, nextState;

    logic [8:0] degreeLatched;
    logic [9:0] gapEnd;      // Last skipped angle, may run past 359
    logic       lastAngle;
    logic       inGap;

    assign gapEnd = {1'b0, degreeLatched} + 10'(hookPkg::GAP_WIDTH);
    assign lastAngle = (angle == 9'(hookPkg::FULL_TURN - 1));

    // Angles from degree through degree + GAP_WIDTH are not drawn
    assign inGap = (angle >= degreeLatched) && ({1'b0, angle} <= gapEnd);

    assign issueValid = (state == hookPkg::RUN) && !inGap;
    assign busy = (state != hookPkg::IDLE);
    assign done = (state == hookPkg::FINISH);

    always_comb begin
        nextState = state;
        case (state)
            hookPkg::IDLE: begin
                if (enable) begin
                    nextState = hookPkg::RUN;
                end
            end
            hookPkg::RUN: begin
                if (!stall && lastAngle) begin
                    nextState = hookPkg::FLUSH;
                end
            end
            hookPkg::FLUSH: begin
                if (drained) begin
                    nextState = hookPkg::FINISH;
                end
            end
            hookPkg::FINISH: nextState = hookPkg::IDLE;
            default:         nextState = hookPkg::IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= hookPkg::IDLE;
            angle <= '0;
        end else begin
            state <= nextState;
            if (state == hookPkg::IDLE) begin
                angle <= '0;                 // Every hook starts at 0 degrees
            end else if (state == hookPkg::RUN && !stall && !lastAngle) begin
                angle <= angle + 9'd1;
            end
        end
    end

    // Request parameters, only captured on accept
    always_ff @(posedge clock) begin
        if (state == hookPkg::IDLE && enable) begin
            degreeLatched <= degree;
        end
    end

endmodule

// ==== hookPkg.sv ====
package hookPkg;

    // Hook geometry
    localparam int HOOK_RADIUS = 18;
    localparam int GAP_WIDTH = 20;   // Degrees skipped after the requested one
    localparam int FULL_TURN = 360;

    // Pixel output flow control
    localparam int PIXEL_CREDITS = 4;
    localparam int CREDIT_BITS = $clog2(PIXEL_CREDITS + 1);

    // Applied by the frame-buffer writer, not by the plotter
    localparam logic [11:0] HOOK_COLOR = 12'hfff;

    // round(HOOK_RADIUS * sin(d)) for d = 0 .. 90 degrees
    localparam logic [4:0] SIN_TABLE [0:90] = '{
        0, 0, 1, 1, 1, 2, 2, 2, 3, 3,
        3, 3, 4, 4, 4, 5, 5, 5, 6, 6,
        6, 6, 7, 7, 7, 8, 8, 8, 8, 9,
        9, 9, 10, 10, 10, 10, 11, 11, 11, 11,
        12, 12, 12, 12, 13, 13, 13, 13, 13, 14,
        14, 14, 14, 14, 15, 15, 15, 15, 15, 15,
        16, 16, 16, 16, 16, 16, 16, 17, 17, 17,
        17, 17, 17, 17, 17, 17, 17, 18, 18, 18,
        18, 18, 18, 18, 18, 18, 18, 18, 18, 18,
        18
    };

    // Sequencer states
    typedef enum logic [1:0] {
        IDLE,    // Waiting for a request
        RUN,     // Stepping the angle
        FLUSH,   // Waiting for the pipeline to empty
        FINISH   // One-cycle done pulse
    } seqState;

endpackage

// ==== hookPlotter.sv ====
`timescale 1ns/1ps

module hookPlotter (
    input  logic       clock,
    input  logic       resetn,
    input  logic       enable,
    input  logic [8:0] centerX,
    input  logic [7:0] centerY,
    input  logic [8:0] degree,
    input  logic       creditReturn,
    output logic       pixelValid,
    output logic [8:0] pixelX,
    output logic [7:0] pixelY,
    output logic       busy,
    output logic       done
);

    logic [8:0]        angle;
    logic              issueValid;
    logic              stall;
    logic              drained;
    logic signed [5:0] xOffset;
    logic signed [5:0] yOffset;

    angleSequencer sequencer (
        .clock      (clock),
        .resetn     (resetn),
        .enable     (enable),
        .degree     (degree),
        .stall      (stall),
        .drained    (drained),
        .angle      (angle),
        .issueValid (issueValid),
        .busy       (busy),
        .done       (done)
    );

    // Cosine for x
    quadrantLookup #(.CosinePhase(1'b1)) xLookup (
        .clock  (clock),
        .resetn (resetn),
        .stall  (stall),
        .angle  (angle),
        .offset (xOffset)
    );

    // Sine for y
    quadrantLookup #(.CosinePhase(1'b0)) yLookup (
        .clock  (clock),
        .resetn (resetn),
        .stall  (stall),
        .angle  (angle),
        .offset (yOffset)
    );

    pixelEmitter emitter (
        .clock        (clock),
        .resetn       (resetn),
        .enable       (enable),
        .busy         (busy),
        .centerX      (centerX),
        .centerY      (centerY),
        .issueValid   (issueValid),
        .xOffset      (xOffset),
        .yOffset      (yOffset),
        .creditReturn (creditReturn),
        .pixelValid   (pixelValid),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .stall        (stall),
        .drained      (drained)
    );

endmodule

// ==== hookPlotter_assert.sv ====
`timescale 1ns/1ps

module hookPlotterAssert (
    input logic clock,
    input logic resetn,
    input logic pixelValid,
    input logic creditReturn,
    input logic busy,
    input logic done
);

    int credits;   // Credits the DUT should still hold, seen from its ports

    always_ff @(posedge clock) begin
        if (!resetn) begin
            credits <= hookPkg::PIXEL_CREDITS;
        end else begin
            credits <= credits + int'(creditReturn) - int'(pixelValid);
        end
    end

    noSendWithoutCredit: assert property (
        @(posedge clock) disable iff (!resetn) pixelValid |-> credits > 0
    ) else $error("pixelValid raised while no credit was left");

    doneSingleCycle: assert property (
        @(posedge clock) disable iff (!resetn) done |=> !done
    ) else $error("done stayed high for more than one cycle");

    idleAfterDone: assert property (
        @(posedge clock) disable iff (!resetn) done |=> !busy
    ) else $error("busy still high in the cycle after done");

endmodule

// ==== hookPlotter_tb.sv ====
`timescale 1ns/1ps

module hookPlotter_tb;

    localparam int WAIT_LIMIT = 20000;   // Cycles per wait, well beyond a heavily stalled hook

    logic       clock;
    logic       resetn;
    logic       enable;
    logic [8:0] centerX;
    logic [7:0] centerY;
    logic [8:0] degree;
    logic       creditReturn;
    logic       pixelValid;
    logic [8:0] pixelX;
    logic [7:0] pixelY;
    logic       busy;
    logic       done;

    integer      seed = 57;
    int          cycleCount = 0;
    int          mismatchErrors = 0;
    int          otherErrors = 0;
    int          pixelCount = 0;
    int          doneCount = 0;
    int          outstanding = 0;   // Pixels sent minus credits returned
    bit          slowSink = 1'b0;
    bit          doneLast = 1'b0;   // done as seen on the previous falling edge
    logic [25:0] expected [$];      // {angle, x, y} in angle order
    int          returnDue [$];     // Cycle at which each credit may go back

    tbClock clockGen (.clock(clock));

    hookPlotter UUT (
        .clock        (clock),
        .resetn       (resetn),
        .enable       (enable),
        .centerX      (centerX),
        .centerY      (centerY),
        .degree       (degree),
        .creditReturn (creditReturn),
        .pixelValid   (pixelValid),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .busy         (busy),
        .done         (done)
    );

    bind hookPlotter hookPlotterAssert protocolChecks (
        .clock        (clock),
        .resetn       (resetn),
        .pixelValid   (pixelValid),
        .creditReturn (creditReturn),
        .busy         (busy),
        .done         (done)
    );

    function automatic int roundReal(input real value);
        if (value < 0.0) begin
            return -$rtoi(0.5 - value);
        end
        return $rtoi(value + 0.5);
    endfunction

    // Circle point around the center with y flipped for screen coordinates
    function automatic logic [16:0] refPixel(input int cx, input int cy, input int angle);
        real rad;
        int  x;
        int  y;
        rad = angle * 3.14159265358979 / 180.0;
        x = cx + roundReal(hookPkg::HOOK_RADIUS * $cos(rad));
        y = cy - roundReal(hookPkg::HOOK_RADIUS * $sin(rad));
        return {9'(x & 511), 8'(y & 255)};   // Wrap to port width
    endfunction

    function automatic int drawDelay();
        int pick;
        pick = int'($unsigned($random(seed)) % 32'd64);
        if (!slowSink) begin
            return pick % 3;
        end
        if (pick < 4) begin
            return 40 + pick * 20;   // Long hold-off that forces a stall
        end
        return pick % 8;
    endfunction

    task automatic checkX(input logic [8:0] got, input logic [8:0] want, input int angle);
        if (got !== want) begin
            $display("Mismatch pixelX at angle %0d: got %h, expected %h", angle, got, want);
            mismatchErrors++;
        end
    endtask

    task automatic checkY(input logic [7:0] got, input logic [7:0] want, input int angle);
        if (got !== want) begin
            $display("Mismatch pixelY at angle %0d: got %h, expected %h", angle, got, want);
            mismatchErrors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("Mismatch %s: got %h, expected %h", name, got, want);
            mismatchErrors++;
        end
    endtask

    // Compare at the falling edge where all outputs are settled
    always @(negedge clock) begin : compare
        logic [25:0] item;
        if (resetn) begin
            if (doneLast) begin
                checkFlag("busy", busy, 1'b0);   // Idle right after the done pulse
            end
            doneLast = done;
            if (pixelValid) begin
                if (outstanding >= hookPkg::PIXEL_CREDITS) begin
                    $display("Pixel sent while the sink already holds %0d pixels", outstanding);
                    otherErrors++;
                end
                pixelCount++;
                outstanding++;
                if (expected.size() == 0) begin
                    $display("Unexpected pixel at (%0d, %0d), nothing left to draw",
                             pixelX, pixelY);
                    otherErrors++;
                end else begin
                    item = expected.pop_front();
                    checkX(pixelX, item[16:8], int'(item[25:17]));
                    checkY(pixelY, item[7:0], int'(item[25:17]));
                end
            end
            if (creditReturn) begin
                outstanding--;
            end
            if (done) begin
                doneCount++;
            end
        end
    end

    always @(negedge clock) begin : sinkAccept
        if (resetn && pixelValid) begin
            returnDue.push_back(cycleCount + drawDelay());
        end
    end

    // Credits go back in order and at most one per cycle
    always @(posedge clock) begin : sinkReturn
        cycleCount++;
        #1;
        if (returnDue.size() > 0 && returnDue[0] <= cycleCount) begin
            creditReturn = 1'b1;
            void'(returnDue.pop_front());
        end else begin
            creditReturn = 1'b0;
        end
    end

    task automatic waitIdle();
        int guard;
        guard = 0;
        @(negedge clock);
        while (busy && guard < WAIT_LIMIT) begin
            @(negedge clock);
            guard++;
        end
        if (busy) begin
            $display("Timed out waiting for the plotter to become idle");
            otherErrors++;
        end
    endtask

    task automatic waitForDone();
        int guard;
        guard = 0;
        @(negedge clock);
        while (!done && guard < WAIT_LIMIT) begin
            @(negedge clock);
            guard++;
        end
        if (!done) begin
            $display("Timed out waiting for done, %0d pixels still missing", expected.size());
            otherErrors++;
        end else if (expected.size() != 0) begin
            $display("done came while %0d pixels were still missing", expected.size());
            otherErrors++;
        end
    endtask

    task automatic runHook(input logic [8:0] cx, input logic [7:0] cy, input logic [8:0] deg,
                           input bit slow, input bit pokeWhileBusy);
        int count;
        int a;
        slowSink = slow;
        count = 0;
        waitIdle();
        pixelCount = 0;
        doneCount = 0;
        @(posedge clock);
        #1;
        centerX = cx;
        centerY = cy;
        degree = deg;
        enable = 1'b1;
        for (a = 0; a < hookPkg::FULL_TURN; a++) begin
            if (a < int'(deg) || a > int'(deg) + hookPkg::GAP_WIDTH) begin
                expected.push_back({9'(a), refPixel(int'(cx), int'(cy), a)});
                count++;
            end
        end
        @(posedge clock);
        #1;
        enable = 1'b0;
        if (pokeWhileBusy) begin
            repeat (20) @(posedge clock);
            #1;
            centerX = 9'd300;   // Would move every later pixel if taken
            centerY = 8'd10;
            degree = 9'd0;
            enable = 1'b1;
            @(posedge clock);
            #1;
            enable = 1'b0;
        end
        waitForDone();
        repeat (10) @(negedge clock);
        if (pixelCount != count) begin
            $display("Hook at degree %0d gave %0d pixels, expected %0d", deg, pixelCount, count);
            otherErrors++;
        end
        if (doneCount != 1) begin
            $display("done pulsed %0d times for one request", doneCount);
            otherErrors++;
        end
        checkFlag("busy", busy, 1'b0);
    endtask

    initial begin
        resetn = 1'b0;
        enable = 1'b0;
        centerX = '0;
        centerY = '0;
        degree = '0;
        creditReturn = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        resetn = 1'b1;
        @(negedge clock);
        checkFlag("busy", busy, 1'b0);
        checkFlag("pixelValid", pixelValid, 1'b0);
        checkFlag("done", done, 1'b0);

        runHook(9'd160, 8'd120, 9'd90, 1'b0, 1'b0);
        runHook(9'd160, 8'd120, 9'd345, 1'b0, 1'b0);   // Gap runs past 359
        runHook(9'd100, 8'd200, 9'd180, 1'b1, 1'b1);   // Back-pressure and ignored enable
        runHook(9'd5, 8'd3, 9'd200, 1'b1, 1'b0);       // Wraps on both axes
        runHook(9'd315, 8'd250, 9'd0, 1'b0, 1'b1);

        $display("Errors: %0d mismatches, %0d other failures", mismatchErrors, otherErrors);
        if (mismatchErrors + otherErrors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== pixelEmitter.sv ====
`timescale 1ns/1ps

module pixelEmitter (
    input  logic              clock,
    input  logic              resetn,
    input  logic              enable,
    input  logic              busy,
    input  logic        [8:0] centerX,
    input  logic        [7:0] centerY,
    input  logic              issueValid,
    input  logic signed [5:0] xOffset,
    input  logic signed [5:0] yOffset,
    input  logic              creditReturn,
    output logic              pixelValid,
    output logic        [8:0] pixelX,
    output logic        [7:0] pixelY,
    output logic              stall,
    output logic              drained
);

    logic [8:0] centerXLatched;
    logic [7:0] centerYLatched;
    logic       delayValid;      // issueValid aligned with the lookup outputs
    logic       outValid;        // Output register holds a pixel
    logic [hookPkg::CREDIT_BITS-1:0] credits;
    logic       haveCredit;
    logic       loadOut;
    logic [8:0] nextX;
    logic [7:0] nextY;

    assign haveCredit = (credits != '0);

    // The held pixel leaves only with a credit in hand
    assign pixelValid = outValid && haveCredit;

    // Freeze upstream when the stage ahead has nowhere to go
    assign stall = outValid && !haveCredit && delayValid;
    assign loadOut = delayValid && !stall;

    assign drained = !delayValid && !outValid;

    // Screen y grows downward, so the sine offset is subtracted
    assign nextX = centerXLatched + {{3{xOffset[5]}}, xOffset};
    assign nextY = centerYLatched - {{2{yOffset[5]}}, yOffset};

    always_ff @(posedge clock) begin
        if (enable && !busy) begin
            centerXLatched <= centerX;
            centerYLatched <= centerY;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            delayValid <= 1'b0;
        end else if (!stall) begin
            delayValid <= issueValid;
        end
    end

    // One-entry output register
    always_ff @(posedge clock) begin
        if (!resetn) begin
            outValid <= 1'b0;
        end else if (loadOut) begin
            outValid <= 1'b1;
        end else if (pixelValid) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (loadOut) begin
            pixelX <= nextX;
            pixelY <= nextY;
        end
    end

    // Credit counter, return and send may coincide
    always_ff @(posedge clock) begin
        if (!resetn) begin
            credits <= hookPkg::PIXEL_CREDITS[hookPkg::CREDIT_BITS-1:0];
        end else begin
            case ({creditReturn, pixelValid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// ==== quadrantLookup.sv ====
`timescale 1ns/1ps

module quadrantLookup #(
    parameter bit CosinePhase = 1'b0   // Set for the x (cosine) offset
) (
    input  logic              clock,
    input  logic              resetn,
    input  logic              stall,
    input  logic        [8:0] angle,
    output logic signed [5:0] offset
);

    logic        [8:0] phased;
    logic        [6:0] tableIndex;   // Folded angle, 0 to 90
    logic              negative;
    logic signed [5:0] magnitude;

    // cos(a) is read as sin(a + 90)
    always_comb begin
        phased = angle;
        if (CosinePhase) begin
            phased = angle + 9'd90;
            if (phased >= 9'(hookPkg::FULL_TURN)) begin
                phased = phased - 9'(hookPkg::FULL_TURN);
            end
        end
    end

    // Fold into the first quadrant and keep the sign
    always_comb begin
        if (phased <= 9'd90) begin
            tableIndex = phased[6:0];
            negative = 1'b0;
        end else if (phased <= 9'd180) begin
            tableIndex = 7'(9'd180 - phased);
            negative = 1'b0;
        end else if (phased <= 9'd270) begin
            tableIndex = 7'(phased - 9'd180);
            negative = 1'b1;
        end else begin
            tableIndex = 7'(9'd360 - phased);
            negative = 1'b1;
        end
    end

    assign magnitude = {1'b0, hookPkg::SIN_TABLE[tableIndex]};

    always_ff @(posedge clock) begin
        if (!resetn) begin
            offset <= '0;
        end else if (!stall) begin
            offset <= negative ? -magnitude : magnitude;   // Held under stall
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the hook plotter testbench with Verilator, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module hookPlotter_tb -f all.f \
    && ./obj_dir/VhookPlotter_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Result: FAILED" sim.log && echo "Simulation reported failure" && exit 1
grep -q "Result: PASSED" sim.log || { echo "Simulation did not complete"; exit 1; }
exit 0

// ==== tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
    output logic clock
);

    // 4 ns period, first rising edge at 2 ns
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

endmodule
